// File: Bender.yml
package:
  name: mxu

sources:
  - source/mxu_pkg.sv
  - source/mxu_control.sv
  - source/weight_memory.sv
  - source/input_skew.sv
  - source/mac_cell.sv
  - source/systolic_array.sv
  - source/output_deskew.sv
  - source/mxu_top.sv
  - target: test
    files:
      - tests/mxu_props.sv
      - tests/mxu_tb.sv

// File: build.f
source/mxu_pkg.sv
source/mxu_control.sv
source/weight_memory.sv
source/input_skew.sv
source/mac_cell.sv
source/systolic_array.sv
source/output_deskew.sv
source/mxu_top.sv
tests/mxu_props.sv
tests/mxu_tb.sv

// File: source/input_skew.sv
module input_skew #(
    parameter int ROWS   = mxu_pkg::ROWS_DEF,
    parameter int DATA_W = mxu_pkg::DATA_W_DEF
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load_data,
    input  logic                   enable_enskew,
    input  logic [ROWS*DATA_W-1:0] infifo_data,
    output logic [ROWS*DATA_W-1:0] row_in
);
    logic [ROWS*DATA_W-1:0] x_hold;

    // vector stays put for the whole compute window
    always_ff @(posedge clk) begin
        if (load_data) begin
            x_hold <= infifo_data;
        end
    end

    //////////////////////////////
    // staircase, row r lags r cycles
    //////////////////////////////
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        logic [DATA_W-1:0] row_q;

        if (r == 0) begin : g_direct
            assign row_q = x_hold[0 +: DATA_W];
        end else begin : g_delay
            logic [DATA_W-1:0] stage [r];

            always_ff @(posedge clk) begin
                if (!reset) begin
                    for (int k = 0; k < r; k++) begin
                        stage[k] <= '0;
                    end
                end else if (enable_enskew) begin
                    stage[0] <= x_hold[r*DATA_W +: DATA_W];
                    for (int k = 1; k < r; k++) begin
                        stage[k] <= stage[k-1];
                    end
                end
            end
            assign row_q = stage[r-1];
        end

        // zeros outside compute so nothing stale is multiplied
        assign row_in[r*DATA_W +: DATA_W] = enable_enskew ? row_q : '0;
    end

endmodule

// File: source/mac_cell.sv
module mac_cell #(
    parameter int DATA_W = mxu_pkg::DATA_W_DEF,
    parameter int ACC_W  = mxu_pkg::acc_width(mxu_pkg::DATA_W_DEF, mxu_pkg::ROWS_DEF)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable_mxu,
    input  logic              load_data,
    input  logic [DATA_W-1:0] weight_in,
    input  logic [DATA_W-1:0] x_in,
    input  logic [ACC_W-1:0]  psum_in,
    output logic [DATA_W-1:0] x_out,
    output logic [ACC_W-1:0]  psum_out
);
    logic [DATA_W-1:0] weight_q;

    // stationary weight
    always_ff @(posedge clk) begin
        if (load_data) begin
            weight_q <= weight_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            x_out    <= '0;
            psum_out <= '0;
        end else if (enable_mxu) begin
            x_out    <= x_in;
            psum_out <= psum_in + ACC_W'(x_in) * ACC_W'(weight_q);
        end
    end

endmodule

// File: source/mxu_control.sv
module mxu_control #(
    parameter int ROWS     = mxu_pkg::ROWS_DEF,
    parameter int COLUMNS  = mxu_pkg::COLUMNS_DEF,
    parameter int WM_DEPTH = mxu_pkg::WM_DEPTH_DEF
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        glb_enable,
    input  logic                        cs_start,
    input  logic                        cs_continue,
    input  logic [$clog2(WM_DEPTH)-1:0] weight_sel,
    input  logic                        infifo_empty,
    input  logic                        outfifo_full,
    output logic                        cs_ready,
    output logic                        cs_done,
    output logic                        cs_idle,
    output logic                        wm_ce,
    output logic [$clog2(WM_DEPTH)-1:0] wm_address,
    output logic                        infifo_read,
    output logic                        load_data,
    output logic                        enable_enskew,
    output logic                        enable_mxu,
    output logic                        enable_deskew,
    output logic                        outfifo_write
);
    import mxu_pkg::*;

    localparam int COMPUTE_LEN = COLUMNS * 4 + 1;
    localparam int FLUSH_LEN   = ROWS + 1;
    localparam int CCNT_W      = $clog2(COMPUTE_LEN + 1);
    localparam int FCNT_W      = $clog2(FLUSH_LEN + 1);

    ctrl_state_e       state;
    logic [CCNT_W-1:0] compute_cnt;
    logic [FCNT_W-1:0] flush_cnt;
    logic              load_step;

    //////////////////////////////
    // state sequencing
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!reset) begin
            state       <= power_up;
            compute_cnt <= '0;
            flush_cnt   <= '0;
            load_step   <= 1'b0;
            wm_address  <= '0;
        end else begin
            case (state)
                power_up: state <= idle;
                idle: begin
                    if (cs_start && glb_enable) begin
                        state      <= start_p1;
                        // weight set is fixed for the whole run
                        wm_address <= weight_sel;
                    end
                end
                // ownership handover, start must stay high throughout
                start_p1: state <= cs_start ? start_p2 : idle;
                start_p2: state <= cs_start ? start_p3 : idle;
                start_p3: state <= cs_start ? retrieve_data : idle;
                retrieve_data: begin
                    if (!infifo_empty) begin
                        state <= load_local;
                    end
                end
                load_local: begin
                    // second cycle lets the loaded operands settle
                    load_step <= ~load_step;
                    if (load_step) begin
                        state       <= compute;
                        compute_cnt <= '0;
                    end
                end
                compute: begin
                    compute_cnt <= compute_cnt + 1'b1;
                    if (compute_cnt == CCNT_W'(COMPUTE_LEN - 1)) begin
                        state     <= flush;
                        flush_cnt <= '0;
                    end
                end
                flush: begin
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == FCNT_W'(FLUSH_LEN - 1)) begin
                        state <= save_to_fifo;
                    end
                end
                save_to_fifo: begin
                    if (!outfifo_full) begin
                        state <= done_st;
                    end
                end
                done_st: state <= (cs_continue && !infifo_empty) ? retrieve_data : idle;
                default: state <= power_up;
            endcase
        end
    end

    // strobe decode, everything low unless the state asks for it
    always_comb begin
        cs_ready      = 1'b0;
        cs_done       = 1'b0;
        cs_idle       = 1'b0;
        wm_ce         = 1'b0;
        infifo_read   = 1'b0;
        load_data     = 1'b0;
        enable_enskew = 1'b0;
        enable_mxu    = 1'b0;
        enable_deskew = 1'b0;
        outfifo_write = 1'b0;
        case (state)
            idle:     cs_idle  = 1'b1;
            start_p3: cs_ready = cs_start;
            retrieve_data: begin
                // weights and input vector are fetched together
                infifo_read = !infifo_empty;
                wm_ce       = !infifo_empty;
            end
            load_local: load_data = !load_step;
            compute: begin
                enable_enskew = 1'b1;
                enable_mxu    = 1'b1;
            end
            flush: begin
                enable_deskew = 1'b1;
                enable_mxu    = 1'b1;
            end
            save_to_fifo: outfifo_write = !outfifo_full;
            done_st:      cs_done       = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: source/mxu_pkg.sv
package mxu_pkg;

    //////////////////////////////
    // default array sizes
    //////////////////////////////
    parameter int ROWS_DEF     = 3;
    parameter int COLUMNS_DEF  = 3;
    parameter int DATA_W_DEF   = 8;
    parameter int WM_DEPTH_DEF = 4;

    // product width plus growth over the rows, plus one spare bit
    function automatic int acc_width(input int data_w, input int rows);
        return 2 * data_w + $clog2(rows) + 1;
    endfunction

    //////////////////////////////
    // controller states
    //////////////////////////////
    typedef enum logic [3:0] {
        power_up      = 4'h0,
        idle          = 4'h1,
        start_p1      = 4'h2,
        start_p2      = 4'h3,
        start_p3      = 4'h4,
        retrieve_data = 4'h5,
        load_local    = 4'h6,
        compute       = 4'h7,
        flush         = 4'h8,
        save_to_fifo  = 4'h9,
        done_st       = 4'hA
    } ctrl_state_e;

endpackage

// File: source/mxu_top.sv
module mxu_top #(
    parameter int ROWS     = mxu_pkg::ROWS_DEF,
    parameter int COLUMNS  = mxu_pkg::COLUMNS_DEF,
    parameter int DATA_W   = mxu_pkg::DATA_W_DEF,
    parameter int WM_DEPTH = mxu_pkg::WM_DEPTH_DEF
) (
    input  logic                                             clk,
    input  logic                                             reset,
    input  logic                                             glb_enable,
    input  logic                                             cs_start,
    input  logic                                             cs_continue,
    input  logic [$clog2(WM_DEPTH)-1:0]                      weight_sel,
    input  logic                                             wm_load_we,
    input  logic [$clog2(WM_DEPTH)-1:0]                      wm_load_addr,
    input  logic [ROWS*COLUMNS*DATA_W-1:0]                   wm_load_data,
    input  logic [ROWS*DATA_W-1:0]                           infifo_data,
    input  logic                                             infifo_empty,
    input  logic                                             outfifo_full,
    output logic                                             cs_ready,
    output logic                                             cs_done,
    output logic                                             cs_idle,
    output logic                                             infifo_read,
    output logic                                             outfifo_write,
    output logic [COLUMNS*mxu_pkg::acc_width(DATA_W, ROWS)-1:0] outfifo_data
);
    import mxu_pkg::*;

    localparam int ACC_W = acc_width(DATA_W, ROWS);

    // controller to datapath
    logic                           wm_ce;
    logic [$clog2(WM_DEPTH)-1:0]    wm_address;
    logic                           load_data;
    logic                           enable_enskew;
    logic                           enable_mxu;
    logic                           enable_deskew;

    // datapath links
    logic [ROWS*COLUMNS*DATA_W-1:0] wm_dout;
    logic [ROWS*DATA_W-1:0]         row_in;
    logic [COLUMNS*ACC_W-1:0]       col_sum;

    mxu_control #(
        .ROWS     (ROWS),
        .COLUMNS  (COLUMNS),
        .WM_DEPTH (WM_DEPTH)
    ) u_control (.*);

    weight_memory #(
        .ROWS     (ROWS),
        .COLUMNS  (COLUMNS),
        .DATA_W   (DATA_W),
        .WM_DEPTH (WM_DEPTH)
    ) u_weight_memory (.*);

    input_skew #(.ROWS(ROWS), .DATA_W(DATA_W)) u_input_skew (.*);

    systolic_array #(
        .ROWS    (ROWS),
        .COLUMNS (COLUMNS),
        .DATA_W  (DATA_W),
        .ACC_W   (ACC_W)
    ) u_array (.*);

    output_deskew #(.COLUMNS(COLUMNS), .ACC_W(ACC_W)) u_output_deskew (.*);

endmodule

// File: source/output_deskew.sv
module output_deskew #(
    parameter int COLUMNS = mxu_pkg::COLUMNS_DEF,
    parameter int ACC_W   = mxu_pkg::acc_width(mxu_pkg::DATA_W_DEF, mxu_pkg::ROWS_DEF)
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     enable_deskew,
    input  logic                     enable_mxu,
    input  logic [COLUMNS*ACC_W-1:0] col_sum,
    output logic [COLUMNS*ACC_W-1:0] outfifo_data
);
    logic [COLUMNS*ACC_W-1:0] aligned;
    logic                     deskew_q;

    // column c lags COLUMNS-1-c cycles, in step with the array
    for (genvar c = 0; c < COLUMNS; c++) begin : g_col
        localparam int D = COLUMNS - 1 - c;

        if (D == 0) begin : g_direct
            assign aligned[c*ACC_W +: ACC_W] = col_sum[c*ACC_W +: ACC_W];
        end else begin : g_delay
            logic [ACC_W-1:0] dly [D];

            always_ff @(posedge clk) begin
                if (!reset) begin
                    for (int k = 0; k < D; k++) begin
                        dly[k] <= '0;
                    end
                end else if (enable_mxu) begin
                    dly[0] <= col_sum[c*ACC_W +: ACC_W];
                    for (int k = 1; k < D; k++) begin
                        dly[k] <= dly[k-1];
                    end
                end
            end
            assign aligned[c*ACC_W +: ACC_W] = dly[D-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            deskew_q <= 1'b0;
        end else begin
            deskew_q <= enable_deskew;
        end
    end

    // first flush cycle has the full vector lined up
    // held afterwards while the output FIFO is full
    always_ff @(posedge clk) begin
        if (enable_deskew && !deskew_q) begin
            outfifo_data <= aligned;
        end
    end

endmodule

// File: source/systolic_array.sv
module systolic_array #(
    parameter int ROWS    = mxu_pkg::ROWS_DEF,
    parameter int COLUMNS = mxu_pkg::COLUMNS_DEF,
    parameter int DATA_W  = mxu_pkg::DATA_W_DEF,
    parameter int ACC_W   = mxu_pkg::acc_width(mxu_pkg::DATA_W_DEF, mxu_pkg::ROWS_DEF)
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           enable_mxu,
    input  logic                           load_data,
    input  logic [ROWS*COLUMNS*DATA_W-1:0] wm_dout,
    input  logic [ROWS*DATA_W-1:0]         row_in,
    output logic [COLUMNS*ACC_W-1:0]       col_sum
);
    // x moves right, partial sums move down
    logic [DATA_W-1:0] x_link [ROWS][COLUMNS+1];
    logic [ACC_W-1:0]  p_link [ROWS+1][COLUMNS];

    //////////////////////////////
    // array edges
    //////////////////////////////
    for (genvar r = 0; r < ROWS; r++) begin : g_left
        assign x_link[r][0] = row_in[r*DATA_W +: DATA_W];
    end

    for (genvar c = 0; c < COLUMNS; c++) begin : g_edge
        assign p_link[0][c]              = '0;
        assign col_sum[c*ACC_W +: ACC_W] = p_link[ROWS][c];
    end

    //////////////////////////////
    // cell grid
    //////////////////////////////
    for (genvar r = 0; r < ROWS; r++) begin : g_r
        for (genvar c = 0; c < COLUMNS; c++) begin : g_c
            mac_cell #(
                .DATA_W (DATA_W),
                .ACC_W  (ACC_W)
            ) u_cell (
                .clk        (clk),
                .reset      (reset),
                .enable_mxu (enable_mxu),
                .load_data  (load_data),
                .weight_in  (wm_dout[(r*COLUMNS+c)*DATA_W +: DATA_W]),
                .x_in       (x_link[r][c]),
                .psum_in    (p_link[r][c]),
                .x_out      (x_link[r][c+1]),
                .psum_out   (p_link[r+1][c])
            );
        end
    end

endmodule

// File: source/weight_memory.sv
module weight_memory #(
    parameter int ROWS     = mxu_pkg::ROWS_DEF,
    parameter int COLUMNS  = mxu_pkg::COLUMNS_DEF,
    parameter int DATA_W   = mxu_pkg::DATA_W_DEF,
    parameter int WM_DEPTH = mxu_pkg::WM_DEPTH_DEF
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wm_ce,
    input  logic [$clog2(WM_DEPTH)-1:0]       wm_address,
    input  logic                              wm_load_we,
    input  logic [$clog2(WM_DEPTH)-1:0]       wm_load_addr,
    input  logic [ROWS*COLUMNS*DATA_W-1:0]    wm_load_data,
    output logic [ROWS*COLUMNS*DATA_W-1:0]    wm_dout
);
    localparam int WORD_W = ROWS * COLUMNS * DATA_W;

    // one word per weight set, cell (r,c) at slot r*COLUMNS+c
    logic [WORD_W-1:0] mem [WM_DEPTH];

    // external load port, whole sets only
    always_ff @(posedge clk) begin
        if (wm_load_we) begin
            mem[wm_load_addr] <= wm_load_data;
        end
    end

    // registered read for the controller
    always_ff @(posedge clk) begin
        if (!reset) begin
            wm_dout <= '0;
        end else if (wm_ce) begin
            wm_dout <= mem[wm_address];
        end
    end

endmodule

// File: tests/mxu_props.sv
module mxu_props (
    input logic clk,
    input logic reset,
    input logic cs_ready,
    input logic cs_done,
    input logic wm_ce,
    input logic infifo_empty,
    input logic infifo_read,
    input logic outfifo_full,
    input logic outfifo_write,
    input logic load_data,
    input logic enable_enskew,
    input logic enable_mxu,
    input logic enable_deskew
);
    // failed assertions so far
    int fail_cnt = 0;

    // fifo strobes respect the flags
    a_read_not_empty: assert property (@(posedge clk) disable iff (!reset)
        infifo_read |-> !infifo_empty)
        else begin
            fail_cnt++;
            $error("input FIFO read while empty");
        end

    a_write_not_full: assert property (@(posedge clk) disable iff (!reset)
        outfifo_write |-> !outfifo_full)
        else begin
            fail_cnt++;
            $error("output FIFO written while full");
        end

    // handshake pulses last one cycle
    a_ready_pulse: assert property (@(posedge clk) disable iff (!reset)
        cs_ready |=> !cs_ready)
        else begin
            fail_cnt++;
            $error("cs_ready held longer than one cycle");
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset)
        cs_done |=> !cs_done)
        else begin
            fail_cnt++;
            $error("cs_done held longer than one cycle");
        end

    // power_up cycle is quiet
    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(reset) |-> !(cs_ready || cs_done || wm_ce || infifo_read || load_data ||
                           enable_enskew || enable_mxu || enable_deskew || outfifo_write))
        else begin
            fail_cnt++;
            $error("strobe active in the first cycle after reset");
        end

endmodule

bind mxu_control mxu_props u_props (.*);

// File: tests/mxu_tb.sv
module mxu_tb;
    import mxu_pkg::*;

    localparam int ROWS     = ROWS_DEF;
    localparam int COLUMNS  = COLUMNS_DEF;
    localparam int DATA_W   = DATA_W_DEF;
    localparam int WM_DEPTH = WM_DEPTH_DEF;
    localparam int ACC_W    = acc_width(DATA_W, ROWS);
    localparam int WSEL_W   = $clog2(WM_DEPTH);
    // vectors in the single, selection, stream and back-pressure tests
    localparam int VECTORS  = 1 + WM_DEPTH + 5 + 2;

    typedef logic [ROWS*COLUMNS*DATA_W-1:0] weight_t;
    typedef logic [ROWS*DATA_W-1:0]         vec_t;
    typedef logic [COLUMNS*ACC_W-1:0]       result_t;

    logic clk;
    logic reset;
    logic glb_enable;
    logic cs_start;
    logic cs_continue;
    logic [WSEL_W-1:0] weight_sel;
    logic wm_load_we;
    logic [WSEL_W-1:0] wm_load_addr;
    weight_t wm_load_data;
    vec_t infifo_data;
    logic infifo_empty;
    logic outfifo_full;
    logic cs_ready;
    logic cs_done;
    logic cs_idle;
    logic infifo_read;
    logic outfifo_write;
    result_t outfifo_data;

    weight_t wsets [WM_DEPTH];
    vec_t    in_q [$];
    result_t out_q [$];
    result_t exp_q [$];
    int errors = 0;
    int checks = 0;
    int read_cnt = 0;
    int write_cnt = 0;
    int ready_cnt = 0;
    int done_cnt = 0;

    mxu_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // fifo models and event counters
    //////////////////////////////
    always @(posedge clk) begin
        if (infifo_read && in_q.size() > 0) begin
            infifo_data <= in_q.pop_front();
        end
        infifo_empty <= (in_q.size() == 0);
        if (outfifo_write) begin
            out_q.push_back(outfifo_data);
        end
        read_cnt  <= read_cnt + int'(infifo_read);
        write_cnt <= write_cnt + int'(outfifo_write);
        ready_cnt <= ready_cnt + int'(cs_ready);
        done_cnt  <= done_cnt + int'(cs_done);
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // y[c] = sum over r of x[r] * W[r][c]
    function automatic result_t model_result(input weight_t w, input vec_t x);
        result_t y;
        logic [ACC_W-1:0] acc;
        y = '0;
        for (int c = 0; c < COLUMNS; c++) begin
            acc = '0;
            for (int r = 0; r < ROWS; r++) begin
                acc += ACC_W'(x[r*DATA_W +: DATA_W]) *
                       ACC_W'(w[(r*COLUMNS+c)*DATA_W +: DATA_W]);
            end
            y[c*ACC_W +: ACC_W] = acc;
        end
        return y;
    endfunction

    function automatic vec_t random_vector();
        vec_t v;
        for (int r = 0; r < ROWS; r++) begin
            v[r*DATA_W +: DATA_W] = DATA_W'($urandom);
        end
        return v;
    endfunction

    task automatic load_weights();
        weight_t w;
        for (int s = 0; s < WM_DEPTH; s++) begin
            for (int i = 0; i < ROWS * COLUMNS; i++) begin
                w[i*DATA_W +: DATA_W] = DATA_W'($urandom);
            end
            wsets[s] = w;
            @(posedge clk);
            wm_load_we   <= 1'b1;
            wm_load_addr <= WSEL_W'(s);
            wm_load_data <= w;
        end
        @(posedge clk);
        wm_load_we <= 1'b0;
    endtask

    // new vector and its expected result
    task automatic push_vector(input int sel);
        vec_t x;
        x = random_vector();
        @(negedge clk);
        in_q.push_back(x);
        exp_q.push_back(model_result(wsets[sel], x));
    endtask

    task automatic start_run(input int sel, input logic cont);
        @(posedge clk);
        weight_sel  <= WSEL_W'(sel);
        cs_continue <= cont;
        cs_start    <= 1'b1;
        do @(posedge clk); while (!cs_ready);
        cs_start <= 1'b0;
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (!cs_idle);
    endtask

    task automatic compare_outputs(input string name);
        check_value({name, " count"}, exp_q.size(), out_q.size());
        while (exp_q.size() > 0 && out_q.size() > 0) begin
            check_value(name, exp_q.pop_front(), out_q.pop_front());
        end
        exp_q.delete();
        out_q.delete();
    endtask

    task automatic run_single(input int sel, input string name);
        int done0;
        int read0;
        done0 = done_cnt;
        read0 = read_cnt;
        push_vector(sel);
        start_run(sel, 1'b0);
        wait_idle();
        check_value({name, " done"}, 1, done_cnt - done0);
        check_value({name, " reads"}, 1, read_cnt - read0);
        compare_outputs(name);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic test_reset_idle();
        repeat (4) @(posedge clk);
        check_value("reset idle", 1, cs_idle);
        check_value("reset reads", 0, read_cnt);
        check_value("reset writes", 0, write_cnt);
    endtask

    task automatic test_single();
        load_weights();
        run_single(0, "single");
    endtask

    task automatic test_weight_select();
        for (int s = 0; s < WM_DEPTH; s++) begin
            run_single(s, $sformatf("weight_sel %0d", s));
        end
    endtask

    task automatic test_streaming();
        int read0;
        read0 = read_cnt;
        repeat (5) push_vector(2);
        start_run(2, 1'b1);
        wait_idle();
        cs_continue <= 1'b0;
        check_value("stream reads", 5, read_cnt - read0);
        check_value("stream left", 0, in_q.size());
        compare_outputs("stream");
    endtask

    task automatic test_backpressure();
        int write0;
        @(posedge clk);
        outfifo_full <= 1'b1;
        // input queue starts empty so the controller parks in retrieve_data
        start_run(1, 1'b1);
        repeat (20) @(posedge clk);
        push_vector(1);
        push_vector(1);
        write0 = write_cnt;
        repeat (60) @(posedge clk);
        check_value("backpressure held", write0, write_cnt);
        outfifo_full <= 1'b0;
        wait_idle();
        cs_continue <= 1'b0;
        compare_outputs("backpressure");
    endtask

    task automatic test_abort();
        int read0;
        int ready0;
        int write0;
        read0  = read_cnt;
        ready0 = ready_cnt;
        write0 = write_cnt;
        // data waiting that must not be taken
        @(negedge clk);
        in_q.push_back(random_vector());
        @(posedge clk);
        cs_start <= 1'b1;
        repeat (2) @(posedge clk);
        cs_start <= 1'b0;
        repeat (6) @(posedge clk);
        glb_enable <= 1'b0;
        cs_start   <= 1'b1;
        repeat (10) @(posedge clk);
        cs_start   <= 1'b0;
        glb_enable <= 1'b1;
        repeat (6) @(posedge clk);
        check_value("abort ready", ready0, ready_cnt);
        check_value("abort reads", read0, read_cnt);
        check_value("abort writes", write0, write_cnt);
        check_value("abort idle", 1, cs_idle);
        @(negedge clk);
        in_q.delete();
    endtask

    initial begin
        void'($urandom(32'hb041c2c3));
        reset        = 1'b0;
        glb_enable   = 1'b1;
        cs_start     = 1'b0;
        cs_continue  = 1'b0;
        weight_sel   = '0;
        wm_load_we   = 1'b0;
        wm_load_addr = '0;
        wm_load_data = '0;
        infifo_data  = '0;
        infifo_empty = 1'b1;
        outfifo_full = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b1;
        test_reset_idle();
        test_single();
        test_weight_select();
        test_streaming();
        test_backpressure();
        test_abort();
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, dut.u_control.u_props.fail_cnt);
        if (errors == 0 && dut.u_control.u_props.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog with a budget per vector
    initial begin
        repeat (16 + 400 * VECTORS) @(posedge clk);
        $display("timeout: the tests did not complete within %0d cycles", 16 + 400 * VECTORS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
